// File: verilog/hc_defines.svh
// Width, depth and CSR address macros for the host channel test node
`ifndef HC_DEFINES_SVH
`define HC_DEFINES_SVH

// One host channel message
`define HC_MSG_W 64

// Source count and per-test message count
`define HC_COUNT_W 31

// Entries in each host FIFO
`define HC_FIFO_DEPTH 8

// CSR data word
`define HC_CSR_W 64

// CSR word addresses
`define HC_ADDR_CTRL   2'd0
`define HC_ADDR_TEST   2'd1
`define HC_ADDR_STATUS 2'd2
`define HC_ADDR_DEBUG  2'd3

`endif

// File: verilog/hc_pkg.sv
// Package with message, count and CSR types and the test mode enum
`default_nettype none

`include "hc_defines.svh"

package hc_pkg;

    // Message as carried by the host FIFOs and the client
    typedef logic [`HC_MSG_W-1:0] msg_t;

    // Source count, also the width of the status message count
    typedef logic [`HC_COUNT_W-1:0] count_t;

    // CSR data and word address
    typedef logic [`HC_CSR_W-1:0] csr_data_t;
    typedef logic [1:0] csr_addr_t;

    // Tester mode
    // Encoding matches the mode field of the test register
    typedef enum logic [1:0]
    {
        MODE_NORMAL   = 2'd0,
        MODE_SINK     = 2'd1,
        MODE_SOURCE   = 2'd2,
        MODE_LOOPBACK = 2'd3
    } test_mode_t;

endpackage

`default_nettype wire

// File: verilog/hc_csr.sv
// CSR block: control bit, one-cycle test request, status and debug read-back
`timescale 1ns/1ps
`default_nettype none

`include "hc_defines.svh"

module hc_csr
(
    input  wire logic                clk,
    input  wire logic                reset_n,

    // CSR access
    input  wire logic                csr_write,
    input  wire logic                csr_read,
    input  wire hc_pkg::csr_addr_t   csr_addr,
    input  wire hc_pkg::csr_data_t   csr_wdata,
    output hc_pkg::csr_data_t        csr_rdata,
    output logic                     csr_rdata_valid,

    // Control register
    output logic                     user_channel_en,

    // Test request, one cycle wide
    output hc_pkg::test_mode_t       test_req_mode,
    output hc_pkg::count_t           test_req_count,

    // Read-back sources
    input  wire logic                status_done,
    input  wire hc_pkg::count_t      status_count,
    input  wire logic [5:0]          debug_state
);

    logic               write_ctrl;
    logic               write_test;
    hc_pkg::test_mode_t wr_mode;
    hc_pkg::csr_data_t  rd_word;

    // Address decode
    // Test register layout: mode in bits 1..0, count from bit 32 up
    always_comb
    begin
        write_ctrl = csr_write && (csr_addr == `HC_ADDR_CTRL);
        write_test = csr_write && (csr_addr == `HC_ADDR_TEST);
        wr_mode    = hc_pkg::test_mode_t'(csr_wdata[1:0]);
    end

    // Control register, bit 0 opens the client tx channel
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            user_channel_en <= 1'b0;
        end
        else if (write_ctrl)
        begin
            user_channel_en <= csr_wdata[0];
        end
    end

    // Test request
    // Nonzero mode write gives a request for exactly one cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            test_req_mode  <= hc_pkg::MODE_NORMAL;
            test_req_count <= '0;
        end
        else if (write_test && (wr_mode != hc_pkg::MODE_NORMAL))
        begin
            test_req_mode  <= wr_mode;
            test_req_count <= csr_wdata[32 +: `HC_COUNT_W];
        end
        else
        begin
            // Count is only looked at while a request is up
            test_req_mode  <= hc_pkg::MODE_NORMAL;
        end
    end

    // Read mux
    // Test register is write-only and reads as zero
    always_comb
    begin
        rd_word = '0;
        case (csr_addr)
            `HC_ADDR_CTRL:   rd_word[0] = user_channel_en;
            `HC_ADDR_STATUS:
            begin
                // Done in bit 0, count above it, bit 32 stays zero
                rd_word[0]               = status_done;
                rd_word[`HC_COUNT_W:1]   = status_count;
            end
            `HC_ADDR_DEBUG:  rd_word[5:0] = debug_state;
            default:         rd_word = '0;
        endcase
    end

    // Fixed one-cycle read latency
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            csr_rdata_valid <= 1'b0;
        end
        else
        begin
            csr_rdata_valid <= csr_read;
        end
    end

    // Read data captured with the strobe
    always_ff @(posedge clk)
    begin
        if (csr_read)
        begin
            csr_rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

// File: verilog/hc_fifo.sv
// Synchronous message FIFO with not_full/not_empty levels and push/pop strobes
`timescale 1ns/1ps
`default_nettype none

`include "hc_defines.svh"

module hc_fifo
#(
    parameter int DEPTH = `HC_FIFO_DEPTH
)
(
    input  wire logic          clk,
    input  wire logic          reset_n,

    // Write side
    input  wire logic          push,
    input  wire hc_pkg::msg_t  push_data,
    output logic               not_full,

    // Read side, head entry always shown
    input  wire logic          pop,
    output hc_pkg::msg_t       pop_data,
    output logic               not_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    // Storage
    hc_pkg::msg_t     mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Levels come from the registered count
    // so a push shows up on not_empty one cycle later
    always_comb
    begin
        not_full  = (count != FULL_CNT);
        not_empty = (count != '0);
        do_push   = push && not_full;
        do_pop    = pop && not_empty;
        pop_data  = mem[rd_ptr];
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap at DEPTH, count tracks occupancy
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/hc_tester.sv
// Test mode FSM, source down-counter, message routing and debug snapshot
`timescale 1ns/1ps
`default_nettype none

`include "hc_defines.svh"

module hc_tester
(
    input  wire logic                 clk,
    input  wire logic                 reset_n,

    // From the CSR block
    input  wire logic                 user_channel_en,
    input  wire hc_pkg::test_mode_t   test_req_mode,
    input  wire hc_pkg::count_t       test_req_count,

    // Host rx FIFO, read side
    input  wire hc_pkg::msg_t         rx_data,
    input  wire logic                 rx_rdy,
    output logic                      rx_enable,

    // Host tx FIFO, write side
    output hc_pkg::msg_t              tx_data,
    input  wire logic                 tx_rdy,
    output logic                      tx_enable,

    // Client channels
    output hc_pkg::msg_t              client_rx_data,
    output logic                      client_rx_rdy,
    input  wire logic                 client_rx_enable,
    input  wire hc_pkg::msg_t         client_tx_data,
    output logic                      client_tx_rdy,
    input  wire logic                 client_tx_enable,

    // To the status block
    output logic                      test_active,
    output logic                      test_done,
    output logic [5:0]                debug_state
);

    hc_pkg::test_mode_t mode;

    // Remaining source messages
    hc_pkg::count_t     source_count;
    logic               source_last;

    always_comb
    begin
        // Pass-through by default
        client_rx_data = rx_data;
        client_rx_rdy  = rx_rdy;
        rx_enable      = client_rx_enable;
        tx_data        = client_tx_data;
        client_tx_rdy  = tx_rdy && user_channel_en;
        tx_enable      = client_tx_enable;
        test_done      = 1'b0;
        source_last    = (source_count == hc_pkg::count_t'(1));

        case (mode)
            hc_pkg::MODE_SINK:
            begin
                // Client locked out, pop only if a final push would fit
                client_rx_rdy = 1'b0;
                client_tx_rdy = 1'b0;
                rx_enable     = rx_rdy && tx_rdy;
                test_done     = rx_enable && rx_data[0];
                // Terminating message goes back to the host once
                tx_data       = rx_data;
                tx_enable     = test_done;
            end
            hc_pkg::MODE_SOURCE:
            begin
                client_rx_rdy = 1'b0;
                client_tx_rdy = 1'b0;
                // Drain whatever the host sends meanwhile
                rx_enable     = rx_rdy;
                // Low bits: remaining count then the last flag
                tx_data                 = '0;
                tx_data[`HC_COUNT_W:0]  = {source_count, source_last};
                tx_enable     = tx_rdy;
                test_done     = tx_rdy && source_last;
            end
            hc_pkg::MODE_LOOPBACK:
            begin
                client_rx_rdy = 1'b0;
                client_tx_rdy = 1'b0;
                // Take a message only when it can go straight back
                rx_enable     = rx_rdy && tx_rdy;
                tx_data       = rx_data;
                tx_enable     = rx_enable;
                test_done     = rx_enable && rx_data[0];
            end
            default:
            begin
                // Normal mode keeps the pass-through above
                test_done     = 1'b0;
            end
        endcase

        test_active = (mode != hc_pkg::MODE_NORMAL);
    end

    // Down-counter, reloaded while not sourcing
    always_ff @(posedge clk)
    begin
        if (mode != hc_pkg::MODE_SOURCE)
        begin
            source_count <= test_req_count;
        end
        else if (tx_rdy)
        begin
            source_count <= source_count - 1'b1;
        end
    end

    // Mode FSM
    // A request wins over the end of a running test
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            mode <= hc_pkg::MODE_NORMAL;
        end
        else if (test_req_mode != hc_pkg::MODE_NORMAL)
        begin
            mode <= test_req_mode;
        end
        else if (test_done)
        begin
            mode <= hc_pkg::MODE_NORMAL;
        end
    end

    // Debug snapshot of the FIFO strobes and the mode
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            debug_state <= '0;
        end
        else
        begin
            debug_state <= {rx_rdy, rx_enable, tx_rdy, tx_enable, mode};
        end
    end

endmodule

`default_nettype wire

// File: verilog/hc_status.sv
// Per-test message counter and done flag fed by the tester strobes
`timescale 1ns/1ps
`default_nettype none

`include "hc_defines.svh"

module hc_status
(
    input  wire logic          clk,
    input  wire logic          reset_n,

    // Tester state
    input  wire logic          test_active,
    input  wire logic          test_done,

    // Tester pops and pushes
    input  wire logic          rx_enable,
    input  wire logic          tx_enable,

    // To the CSR block
    output logic               status_done,
    output hc_pkg::count_t     status_count
);

    logic       active_q;
    logic       test_start;

    // Pop and push may land in the same cycle
    logic [1:0] step;

    always_comb
    begin
        test_start = test_active && !active_q;
        step       = {1'b0, rx_enable} + {1'b0, tx_enable};
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            active_q     <= 1'b0;
            status_done  <= 1'b0;
            status_count <= '0;
        end
        else
        begin
            active_q <= test_active;

            // New test restarts the count
            // traffic in its first cycle is already included
            if (test_start)
            begin
                status_count <= hc_pkg::count_t'(step);
                status_done  <= 1'b0;
            end
            else if (test_active)
            begin
                status_count <= status_count + hc_pkg::count_t'(step);
            end

            // Set last so a test ending in its first cycle still shows done
            if (test_done)
            begin
                status_done <= 1'b1;
            end
        end
    end

    // Count and done hold after the test until the next one starts

endmodule

`default_nettype wire

// File: verilog/hc_top.sv
// Top level: CSR block, rx and tx FIFOs, tester and status block
`timescale 1ns/1ps
`default_nettype none

`include "hc_defines.svh"

module hc_top
(
    input  wire logic                clk,
    input  wire logic                reset_n,

    // CSR access
    input  wire logic                csr_write,
    input  wire logic                csr_read,
    input  wire hc_pkg::csr_addr_t   csr_addr,
    input  wire hc_pkg::csr_data_t   csr_wdata,
    output wire hc_pkg::csr_data_t   csr_rdata,
    output wire logic                csr_rdata_valid,

    // Host side, rx push and tx pop
    input  wire logic                host_rx_push,
    input  wire hc_pkg::msg_t        host_rx_data,
    output wire logic                host_rx_rdy,
    input  wire logic                host_tx_pop,
    output wire hc_pkg::msg_t        host_tx_data,
    output wire logic                host_tx_rdy,

    // Client side
    output wire hc_pkg::msg_t        client_rx_data,
    output wire logic                client_rx_rdy,
    input  wire logic                client_rx_enable,
    input  wire hc_pkg::msg_t        client_tx_data,
    output wire logic                client_tx_rdy,
    input  wire logic                client_tx_enable
);

    // CSR to tester
    wire logic               user_channel_en;
    wire hc_pkg::test_mode_t test_req_mode;
    wire hc_pkg::count_t     test_req_count;

    // FIFOs to tester
    wire hc_pkg::msg_t       rx_data;
    wire logic               rx_rdy;
    wire logic               rx_enable;
    wire hc_pkg::msg_t       tx_data;
    wire logic               tx_rdy;
    wire logic               tx_enable;

    // Tester and status back to the CSR block
    wire logic               test_active;
    wire logic               test_done;
    wire logic [5:0]         debug_state;
    wire logic               status_done;
    wire hc_pkg::count_t     status_count;

    hc_csr i_hc_csr
    (
        .clk             (clk),
        .reset_n         (reset_n),
        .csr_write       (csr_write),
        .csr_read        (csr_read),
        .csr_addr        (csr_addr),
        .csr_wdata       (csr_wdata),
        .csr_rdata       (csr_rdata),
        .csr_rdata_valid (csr_rdata_valid),
        .user_channel_en (user_channel_en),
        .test_req_mode   (test_req_mode),
        .test_req_count  (test_req_count),
        .status_done     (status_done),
        .status_count    (status_count),
        .debug_state     (debug_state)
    );

    // Host to client
    hc_fifo #(.DEPTH(`HC_FIFO_DEPTH)) i_rx_fifo
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .push      (host_rx_push),
        .push_data (host_rx_data),
        .not_full  (host_rx_rdy),
        .pop       (rx_enable),
        .pop_data  (rx_data),
        .not_empty (rx_rdy)
    );

    // Client to host
    hc_fifo #(.DEPTH(`HC_FIFO_DEPTH)) i_tx_fifo
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .push      (tx_enable),
        .push_data (tx_data),
        .not_full  (tx_rdy),
        .pop       (host_tx_pop),
        .pop_data  (host_tx_data),
        .not_empty (host_tx_rdy)
    );

    hc_tester i_hc_tester
    (
        .clk              (clk),
        .reset_n          (reset_n),
        .user_channel_en  (user_channel_en),
        .test_req_mode    (test_req_mode),
        .test_req_count   (test_req_count),
        .rx_data          (rx_data),
        .rx_rdy           (rx_rdy),
        .rx_enable        (rx_enable),
        .tx_data          (tx_data),
        .tx_rdy           (tx_rdy),
        .tx_enable        (tx_enable),
        .client_rx_data   (client_rx_data),
        .client_rx_rdy    (client_rx_rdy),
        .client_rx_enable (client_rx_enable),
        .client_tx_data   (client_tx_data),
        .client_tx_rdy    (client_tx_rdy),
        .client_tx_enable (client_tx_enable),
        .test_active      (test_active),
        .test_done        (test_done),
        .debug_state      (debug_state)
    );

    hc_status i_hc_status
    (
        .clk          (clk),
        .reset_n      (reset_n),
        .test_active  (test_active),
        .test_done    (test_done),
        .rx_enable    (rx_enable),
        .tx_enable    (tx_enable),
        .status_done  (status_done),
        .status_count (status_count)
    );

endmodule

`default_nettype wire

// File: dv/hc_sva.sv
// Concurrent assertions on the tester and their bind to hc_tester
`timescale 1ns/1ps
`default_nettype none

module hc_sva
(
    input wire logic               clk,
    input wire logic               reset_n,
    input wire hc_pkg::test_mode_t mode,
    input wire hc_pkg::test_mode_t test_req_mode,
    input wire logic               rx_rdy,
    input wire logic               rx_enable,
    input wire logic               tx_rdy,
    input wire logic               tx_enable,
    input wire logic               client_rx_rdy,
    input wire logic               client_tx_rdy,
    input wire logic               test_active,
    input wire logic               test_done,
    input wire logic [5:0]         debug_state
);

    // Pop only from a FIFO that holds data
    rx_enable_needs_ready: assert property (@(posedge clk) disable iff (!reset_n)
        rx_enable |-> rx_rdy)
        else $error("rx FIFO popped while rx_rdy was low");

    // Push only into a FIFO with room
    tx_enable_needs_ready: assert property (@(posedge clk) disable iff (!reset_n)
        tx_enable |-> tx_rdy)
        else $error("tx FIFO pushed while tx_rdy was low");

    // Client locked out in every test mode
    client_idle_in_test: assert property (@(posedge clk) disable iff (!reset_n)
        (mode != hc_pkg::MODE_NORMAL) |-> (!client_rx_rdy && !client_tx_rdy))
        else $error("client ready raised during a test mode");

    // Back to normal right after the end of a test, unless a new request arrives
    normal_after_done: assert property (@(posedge clk) disable iff (!reset_n)
        (test_done && (test_req_mode == hc_pkg::MODE_NORMAL))
            |=> (mode == hc_pkg::MODE_NORMAL))
        else $error("mode did not return to normal after test_done");

    // Control outputs known once out of reset
    no_unknown_control: assert property (@(posedge clk) disable iff (!reset_n)
        !$isunknown({mode, rx_rdy, rx_enable, tx_rdy, tx_enable, client_rx_rdy,
                     client_tx_rdy, test_active, test_done, debug_state}))
        else $error("tester control signal is unknown after reset");

endmodule

// Attached to every tester instance, mode is its internal state
bind hc_tester hc_sva i_hc_sva
(
    .clk           (clk),
    .reset_n       (reset_n),
    .mode          (mode),
    .test_req_mode (test_req_mode),
    .rx_rdy        (rx_rdy),
    .rx_enable     (rx_enable),
    .tx_rdy        (tx_rdy),
    .tx_enable     (tx_enable),
    .client_rx_rdy (client_rx_rdy),
    .client_tx_rdy (client_tx_rdy),
    .test_active   (test_active),
    .test_done     (test_done),
    .debug_state   (debug_state)
);

`default_nettype wire

// File: dv/hc_tb.sv
// Testbench: clock, reset, host and client stimulus, reference queue checks and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "hc_defines.svh"

module hc_tb;

    localparam int RESET_CYCLES = 16;
    localparam int NORMAL_MSGS  = 6;
    localparam int SOURCE_COUNT = 20;
    localparam int POP_GAP      = 3;
    localparam int LOOP_MSGS    = 5;
    localparam int SINK_MSGS    = 4;
    // Sum of the test lengths in cycles, with margin
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 + NORMAL_MSGS * 16
        + SOURCE_COUNT * (POP_GAP + 3) + LOOP_MSGS * 12 + SINK_MSGS * 12 + 500;

    logic               clk;
    logic               reset_n;
    logic               csr_write;
    logic               csr_read;
    hc_pkg::csr_addr_t  csr_addr;
    hc_pkg::csr_data_t  csr_wdata;
    hc_pkg::csr_data_t  csr_rdata;
    logic               csr_rdata_valid;
    logic               host_rx_push;
    hc_pkg::msg_t       host_rx_data;
    logic               host_rx_rdy;
    logic               host_tx_pop;
    hc_pkg::msg_t       host_tx_data;
    logic               host_tx_rdy;
    hc_pkg::msg_t       client_rx_data;
    logic               client_rx_rdy;
    logic               client_rx_enable;
    hc_pkg::msg_t       client_tx_data;
    logic               client_tx_rdy;
    logic               client_tx_enable;

    // Reference queue and bookkeeping
    hc_pkg::msg_t       ref_q[$];
    hc_pkg::msg_t       msg;
    hc_pkg::msg_t       got;
    hc_pkg::csr_data_t  word;
    string              test_name;
    int                 tests;
    int                 checks;
    int                 errors;
    int                 errors_at_start;

    hc_top i_hc_top
    (
        .clk              (clk),
        .reset_n          (reset_n),
        .csr_write        (csr_write),
        .csr_read         (csr_read),
        .csr_addr         (csr_addr),
        .csr_wdata        (csr_wdata),
        .csr_rdata        (csr_rdata),
        .csr_rdata_valid  (csr_rdata_valid),
        .host_rx_push     (host_rx_push),
        .host_rx_data     (host_rx_data),
        .host_rx_rdy      (host_rx_rdy),
        .host_tx_pop      (host_tx_pop),
        .host_tx_data     (host_tx_data),
        .host_tx_rdy      (host_tx_rdy),
        .client_rx_data   (client_rx_data),
        .client_rx_rdy    (client_rx_rdy),
        .client_rx_enable (client_rx_enable),
        .client_tx_data   (client_tx_data),
        .client_tx_rdy    (client_tx_rdy),
        .client_tx_enable (client_tx_enable)
    );

    // 20 ns clock
    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run limit
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles in test %s, DUT stopped responding",
                 WATCHDOG_CYCLES, test_name);
        $display("Verification failed");
        $finish;
    end

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        assert (actual === expected)
        else
        begin
            errors++;
            $display("FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("Test %s finished with %0d errors", test_name, errors - errors_at_start);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // All tasks start and end just after a falling edge
    task automatic write_csr(input hc_pkg::csr_addr_t addr, input hc_pkg::csr_data_t data);
        csr_write = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        @(negedge clk);
        csr_write = 1'b0;
    endtask

    // Read data due exactly one cycle after the strobe
    task automatic read_csr(input hc_pkg::csr_addr_t addr, output hc_pkg::csr_data_t data);
        csr_read = 1'b1;
        csr_addr = addr;
        @(negedge clk);
        csr_read = 1'b0;
        check_value("read valid", 1, csr_rdata_valid);
        data = csr_rdata;
    endtask

    task automatic send_from_host(input hc_pkg::msg_t m);
        while (!host_rx_rdy) @(negedge clk);
        host_rx_push = 1'b1;
        host_rx_data = m;
        @(negedge clk);
        host_rx_push = 1'b0;
    endtask

    task automatic take_at_host(output hc_pkg::msg_t m);
        while (!host_tx_rdy) @(negedge clk);
        m           = host_tx_data;
        host_tx_pop = 1'b1;
        @(negedge clk);
        host_tx_pop = 1'b0;
    endtask

    task automatic send_from_client(input hc_pkg::msg_t m);
        while (!client_tx_rdy) @(negedge clk);
        client_tx_enable = 1'b1;
        client_tx_data   = m;
        @(negedge clk);
        client_tx_enable = 1'b0;
    endtask

    task automatic take_at_client(output hc_pkg::msg_t m);
        while (!client_rx_rdy) @(negedge clk);
        m                = client_rx_data;
        client_rx_enable = 1'b1;
        @(negedge clk);
        client_rx_enable = 1'b0;
    endtask

    // Done flag in bit 0, message count above it
    task automatic check_status(input int expected_count);
        hc_pkg::csr_data_t status;
        read_csr(`HC_ADDR_STATUS, status);
        check_value("status done", 1, status[0]);
        check_value("status count", expected_count, status[32:1]);
    endtask

    // Mode in bits 1..0, source count from bit 32
    function automatic hc_pkg::csr_data_t test_request_word(input hc_pkg::test_mode_t mode,
                                                            input int count);
        hc_pkg::csr_data_t w;
        w = '0;
        w[1:0] = mode;
        w[32 +: `HC_COUNT_W] = count[`HC_COUNT_W-1:0];
        return w;
    endfunction

    // Remaining count, then the last flag
    function automatic hc_pkg::msg_t source_message(input int remaining);
        hc_pkg::msg_t m;
        m = '0;
        m[31:1] = remaining[30:0];
        m[0] = (remaining == 1);
        return m;
    endfunction

    function automatic hc_pkg::msg_t random_message();
        return {$urandom, $urandom};
    endfunction

    initial
    begin
        reset_n          = 1'b0;
        csr_write        = 1'b0;
        csr_read         = 1'b0;
        csr_addr         = '0;
        csr_wdata        = '0;
        host_rx_push     = 1'b0;
        host_rx_data     = '0;
        host_tx_pop      = 1'b0;
        client_rx_enable = 1'b0;
        client_tx_data   = '0;
        client_tx_enable = 1'b0;
        tests            = 0;
        checks           = 0;
        errors           = 0;
        void'($urandom(3186));

        start_test("reset");
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_value("host_tx_rdy", 0, host_tx_rdy);
        check_value("client_rx_rdy", 0, client_rx_rdy);
        check_value("client_tx_rdy", 0, client_tx_rdy);
        check_value("host_rx_rdy", 1, host_rx_rdy);
        check_value("csr_rdata_valid", 0, csr_rdata_valid);
        read_csr(`HC_ADDR_DEBUG, word);
        check_value("debug mode", 0, word[1:0]);
        end_test();

        // Host to client in order, then client to host once enabled
        start_test("normal");
        for (int i = 0; i < NORMAL_MSGS; i++)
        begin
            msg = random_message();
            ref_q.push_back(msg);
            send_from_host(msg);
        end
        while (ref_q.size() > 0)
        begin
            take_at_client(got);
            check_value("client rx data", ref_q.pop_front(), got);
        end
        check_value("client_tx_rdy with channel off", 0, client_tx_rdy);
        write_csr(`HC_ADDR_CTRL, 64'd1);
        for (int i = 0; i < NORMAL_MSGS; i++)
        begin
            msg = random_message();
            ref_q.push_back(msg);
            send_from_client(msg);
        end
        while (ref_q.size() > 0)
        begin
            take_at_host(got);
            check_value("host tx data", ref_q.pop_front(), got);
        end
        end_test();

        // Late and slow host pops so the tx FIFO fills
        start_test("source");
        write_csr(`HC_ADDR_TEST, test_request_word(hc_pkg::MODE_SOURCE, SOURCE_COUNT));
        wait_cycles(`HC_FIFO_DEPTH + 4);
        for (int k = SOURCE_COUNT; k > 0; k--)
        begin
            take_at_host(got);
            check_value("source message", source_message(k), got);
            wait_cycles(POP_GAP);
        end
        wait_cycles(4);
        check_value("host_tx_rdy after last source message", 0, host_tx_rdy);
        check_status(SOURCE_COUNT);
        end_test();

        // Terminating message has bit 0 set
        start_test("loopback");
        write_csr(`HC_ADDR_TEST, test_request_word(hc_pkg::MODE_LOOPBACK, 0));
        wait_cycles(1);
        for (int i = 0; i < LOOP_MSGS; i++)
        begin
            msg    = random_message();
            msg[0] = (i == LOOP_MSGS - 1);
            ref_q.push_back(msg);
            send_from_host(msg);
        end
        while (ref_q.size() > 0)
        begin
            take_at_host(got);
            check_value("looped message", ref_q.pop_front(), got);
        end
        check_status(2 * LOOP_MSGS);
        // Back in normal mode the host reaches the client again
        msg = random_message();
        send_from_host(msg);
        take_at_client(got);
        check_value("client rx after loopback", msg, got);
        end_test();

        start_test("sink");
        write_csr(`HC_ADDR_TEST, test_request_word(hc_pkg::MODE_SINK, 0));
        wait_cycles(1);
        for (int i = 0; i < SINK_MSGS; i++)
        begin
            msg    = random_message();
            msg[0] = (i == SINK_MSGS - 1);
            send_from_host(msg);
        end
        // Only the terminating message comes back
        take_at_host(got);
        check_value("sink returned message", msg, got);
        wait_cycles(4);
        check_value("host_tx_rdy after sink", 0, host_tx_rdy);
        check_value("client_rx_rdy after sink", 0, client_rx_rdy);
        check_status(SINK_MSGS + 1);
        end_test();

        $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+verilog
verilog/hc_pkg.sv
verilog/hc_csr.sv
verilog/hc_fifo.sv
verilog/hc_tester.sv
verilog/hc_status.sv
verilog/hc_top.sv
dv/hc_sva.sv
dv/hc_tb.sv
